// File: src.f
+incdir+source
source/fabric_pkg.sv
source/fabric_fifo.sv
source/fabric_cfg.sv
source/fabric_pe.sv
source/fabric_tile.sv
tb/tb_fabric_tile.sv

// File: tb/fabric_vectors.txt
# Kinds: T name err_tag_at_end | C cfg_addr cfg_data | P a_tag a_data b_tag b_data
#        A a_tag a_data (A only) | E res_tag res_data ; all numbers hex
T reset_pass 0
P 1 1234 1 ffff
P 2 abcd 2 0001
E 1 1234
E 2 abcd
T op_add 0
C 0 0000
P 3 fff0 3 0020
E 3 0010
T op_sub 0
C 0 0001
P 4 0005 4 0007
E 4 fffe
T op_and 0
C 0 0002
P 5 f0f0 5 ff00
E 5 f000
T op_or 0
C 0 0003
P 6 00f0 6 0f00
E 6 0ff0
T op_xor 0
C 0 0004
P 7 aaaa 7 ffff
E 7 5555
T op_shl 0
C 0 0005
P 8 0003 8 0014
P 9 8001 9 002f
E 8 0030
E 9 8000
T op_max 0
C 0 0006
P a 8000 a 7fff
P b 0010 b 0100
E a 8000
E b 0100
# Same operands twice, once through the output buffer and once bypassed
T add_buffered 0
C 0 0000
C 1 0000
P 1 0001 1 0010
P 2 0102 2 0020
P 3 ffff 3 0003
P 4 7000 4 9000
P 5 1234 5 1111
E 1 0011
E 2 0122
E 3 0002
E 4 0000
E 5 2345
T add_bypass 0
C 1 0001
P 1 0001 1 0010
P 2 0102 2 0020
P 3 ffff 3 0003
P 4 7000 4 9000
P 5 1234 5 1111
E 1 0011
E 2 0122
E 3 0002
E 4 0000
E 5 2345
T const_add 0
C 1 0002
C 2 0100
A 6 0001
A 7 ffff
A 8 0200
E 6 0101
E 7 00ff
E 8 0300
T tag_mismatch 1
C 1 0000
C 0 0004
P 9 00ff a 0f0f
P b 1111 b 0101
E 9 0ff0
E b 1010
T err_held 1
C 0 0007
P c 1111 c 2222
E c 1111

// File: tb/tb_fabric_tile.sv
`timescale 1ns/10ps
`default_nettype none

`include "fabric_params.svh"

module tb_fabric_tile;

  import fabric_pkg::*;

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------
  logic                      clk;
  logic                      rst_n;
  logic                      a_valid;
  logic                      a_ready;
  fabric_token_t             a_tok;
  logic                      b_valid;
  logic                      b_ready;
  fabric_token_t             b_tok;
  logic                      res_valid;
  logic                      res_ready;
  fabric_token_t             res_tok;
  logic                      cfg_we;
  fabric_cfg_addr_e          cfg_addr;
  logic [`FABRIC_DATA_W-1:0] cfg_wdata;
  logic                      err_tag;

  // Parsed vector records, one entry per line
  logic [7:0]                rec_kind [$];
  logic [15:0]               rec_f0 [$];
  logic [15:0]               rec_f1 [$];
  logic [15:0]               rec_f2 [$];
  logic [15:0]               rec_f3 [$];
  string                     rec_name [$];

  // Work of the test in progress
  string                     cur_name;
  logic                      exp_err;
  logic [1:0]                cfg_addr_q [$];
  logic [15:0]               cfg_data_q [$];
  fabric_token_t             a_q [$];
  fabric_token_t             b_q [$];
  fabric_token_t             exp_q [$];

  bit                        load_ok = 1'b0;
  int                        token_total = 0;
  int                        cycles = 0;
  int                        cycle_limit = 100000;
  int                        test_errs = 0;
  int                        pass_count = 0;
  int                        fail_count = 0;
  int                        b_used = 0;
  int                        b_rdy_cycles = 0;

  fabric_tile DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .a_tok     (a_tok),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .b_tok     (b_tok),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_tok   (res_tok),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .err_tag   (err_tag)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit from the vector length
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, results still outstanding", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Random back-pressure on the result stream
  task automatic drive_res_ready();
    forever begin
      @(negedge clk);
      res_ready = (($urandom % 4) != 0);
    end
  endtask

  // --------------------------------------------------
  // Result monitor, values sampled before the edge updates
  // --------------------------------------------------
  always @(posedge clk) begin : monitor
    fabric_token_t exp_tok;
    if (rst_n && res_valid && res_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("Unexpected extra result %h in test %s", res_tok, cur_name);
        test_errs++;
      end
      if (exp_q.size() != 0) begin
        exp_tok = exp_q.pop_front();
        assert (res_tok == exp_tok) else begin
          $display("ERROR %s: result expected %h got %h", cur_name, exp_tok, res_tok);
          test_errs++;
        end
      end
    end
    // B consumption seen at the PE join
    if (rst_n && DUT.u_pe.b_valid && DUT.u_pe.b_ready) begin
      b_used++;
    end
    if (rst_n && DUT.u_pe.b_ready) begin
      b_rdy_cycles++;
    end
  end

  // --------------------------------------------------
  // Vector file reader
  // --------------------------------------------------
  task automatic load_vectors();
    int                fd;
    int                rc;
    logic [7:0]        kind;
    string             name;
    logic [15:0]       f0;
    logic [15:0]       f1;
    logic [15:0]       f2;
    logic [15:0]       f3;
    logic [8*160-1:0]  skip_buf;
    fd = $fopen("tb/fabric_vectors.txt", "r");
    load_ok = (fd != 0);
    if (load_ok) begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        f0 = '0;
        f1 = '0;
        f2 = '0;
        f3 = '0;
        case (kind)
          "#": rc = $fgets(skip_buf, fd);
          "T": begin
            rc = $fscanf(fd, " %s %h", name, f0);
            rec_name.push_back(name);
          end
          "P": rc = $fscanf(fd, " %h %h %h %h", f0, f1, f2, f3);
          default: rc = $fscanf(fd, " %h %h", f0, f1);
        endcase
        if (kind != "#") begin
          rec_kind.push_back(kind);
          rec_f0.push_back(f0);
          rec_f1.push_back(f1);
          rec_f2.push_back(f2);
          rec_f3.push_back(f3);
        end
        if (kind == "P" || kind == "A" || kind == "E") begin
          token_total++;
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic write_cfg(input logic [1:0] addr, input logic [15:0] data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = fabric_cfg_addr_e'(addr);
    cfg_wdata = data;
    @(negedge clk);
    cfg_we    = 1'b0;
  endtask

  // A stream with random idle gaps, token held until taken
  task automatic drive_a();
    fabric_token_t tok;
    while (a_q.size() != 0) begin
      tok = a_q.pop_front();
      @(negedge clk);
      while (($urandom % 4) == 0) begin
        a_valid = 1'b0;
        @(negedge clk);
      end
      a_valid = 1'b1;
      a_tok   = tok;
      @(posedge clk);
      while (!a_ready) @(posedge clk);
    end
    @(negedge clk);
    a_valid = 1'b0;
  endtask

  task automatic drive_b();
    fabric_token_t tok;
    while (b_q.size() != 0) begin
      tok = b_q.pop_front();
      @(negedge clk);
      while (($urandom % 4) == 0) begin
        b_valid = 1'b0;
        @(negedge clk);
      end
      b_valid = 1'b1;
      b_tok   = tok;
      @(posedge clk);
      while (!b_ready) @(posedge clk);
    end
    @(negedge clk);
    b_valid = 1'b0;
  endtask

  // Config writes, both streams, then wait for every result
  task automatic run_test();
    int n_b;
    n_b          = b_q.size();
    test_errs    = 0;
    while (cfg_addr_q.size() != 0) begin
      write_cfg(cfg_addr_q.pop_front(), cfg_data_q.pop_front());
    end
    b_used       = 0;
    b_rdy_cycles = 0;
    fork
      drive_a();
      drive_b();
    join
    while (exp_q.size() != 0) @(posedge clk);
    @(negedge clk);
    assert (err_tag == exp_err) else begin
      $display("ERROR %s: err_tag expected %0b got %0b", cur_name, exp_err, err_tag);
      test_errs++;
    end
    assert (b_used == n_b) else begin
      $display("ERROR %s: B tokens consumed expected %0d got %0d", cur_name, n_b, b_used);
      test_errs++;
    end
    // Constant mode keeps the B side closed
    if (n_b == 0) begin
      assert (b_rdy_cycles == 0) else begin
        $display("ERROR %s: b_ready cycles expected 0 got %0d", cur_name, b_rdy_cycles);
        test_errs++;
      end
    end
    if (test_errs == 0) begin
      $display("PASS %s", cur_name);
      pass_count++;
    end else begin
      $display("FAIL %s (%0d errors)", cur_name, test_errs);
      fail_count++;
    end
  endtask

  // Walk the records, one test per T line
  task automatic run_all();
    bit            open;
    fabric_token_t tok;
    open = 1'b0;
    for (int i = 0; i < rec_kind.size(); i++) begin
      case (rec_kind[i])
        "T": begin
          if (open) run_test();
          cur_name = rec_name.pop_front();
          exp_err  = rec_f0[i][0];
          open     = 1'b1;
        end
        "C": begin
          cfg_addr_q.push_back(rec_f0[i][1:0]);
          cfg_data_q.push_back(rec_f1[i]);
        end
        "P": begin
          tok.tag  = rec_f0[i][`FABRIC_TAG_W-1:0];
          tok.data = rec_f1[i];
          a_q.push_back(tok);
          tok.tag  = rec_f2[i][`FABRIC_TAG_W-1:0];
          tok.data = rec_f3[i];
          b_q.push_back(tok);
        end
        "A": begin
          tok.tag  = rec_f0[i][`FABRIC_TAG_W-1:0];
          tok.data = rec_f1[i];
          a_q.push_back(tok);
        end
        "E": begin
          tok.tag  = rec_f0[i][`FABRIC_TAG_W-1:0];
          tok.data = rec_f1[i];
          exp_q.push_back(tok);
        end
        default: begin
        end
      endcase
    end
    if (open) run_test();
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(52));
    rst_n     = 1'b0;
    a_valid   = 1'b0;
    a_tok     = '0;
    b_valid   = 1'b0;
    b_tok     = '0;
    res_ready = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = CFG_OP;
    cfg_wdata = '0;
    load_vectors();
    cycle_limit = 40 * token_total + 200;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fork
      drive_res_ready();
    join_none
    // Idle outputs straight after reset
    assert (!res_valid && !err_tag) else begin
      $display("ERROR reset_state: res_valid,err_tag expected 0,0 got %0b,%0b",
               res_valid, err_tag);
      test_errs++;
    end
    if (test_errs == 0) begin
      $display("PASS reset_state");
      pass_count++;
    end else begin
      $display("FAIL reset_state");
      fail_count++;
    end
    if (!load_ok) begin
      $display("Vector file tb/fabric_vectors.txt could not be opened");
      fail_count++;
    end else begin
      run_all();
    end
    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/fabric_tile.sv
`timescale 1ns/10ps
`default_nettype none

`include "fabric_params.svh"

// --------------------------------------------------
// One dataflow tile: buffers, PE, output buffer
// --------------------------------------------------
module fabric_tile (
  input  wire logic                         clk,
  input  wire logic                         rst_n,

  // Operand stream A
  input  wire logic                         a_valid,
  output logic                              a_ready,
  input  wire fabric_pkg::fabric_token_t    a_tok,

  // Operand stream B
  input  wire logic                         b_valid,
  output logic                              b_ready,
  input  wire fabric_pkg::fabric_token_t    b_tok,

  // Result stream
  output logic                              res_valid,
  input  wire logic                         res_ready,
  output fabric_pkg::fabric_token_t         res_tok,

  // Configuration strobe
  input  wire logic                         cfg_we,
  input  wire fabric_pkg::fabric_cfg_addr_e cfg_addr,
  input  wire logic [`FABRIC_DATA_W-1:0]    cfg_wdata,

  output logic                              err_tag
);

  import fabric_pkg::*;

  // Input buffer to PE
  logic          fa_valid;
  logic          fa_ready;
  fabric_token_t fa_tok;
  logic          fb_valid;
  logic          fb_ready;
  fabric_token_t fb_tok;

  // PE to output buffer
  logic          pe_valid;
  logic          pe_ready;
  fabric_token_t pe_tok;

  fabric_cfg_t   cfg;
  logic          busy;

  // Any token held anywhere in the tile
  assign busy = fa_valid | fb_valid | pe_valid | res_valid;

  // --------------------------------------------------
  // Input buffers, never bypassed
  // --------------------------------------------------

  fabric_fifo #(
    .DEPTH (`FABRIC_IN_DEPTH)
  ) u_fifo_a (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (a_valid),
    .in_ready  (a_ready),
    .in_tok    (a_tok),
    .out_valid (fa_valid),
    .out_ready (fa_ready),
    .out_tok   (fa_tok),
    .bypass    (1'b0)
  );

  fabric_fifo #(
    .DEPTH (`FABRIC_IN_DEPTH)
  ) u_fifo_b (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (b_valid),
    .in_ready  (b_ready),
    .in_tok    (b_tok),
    .out_valid (fb_valid),
    .out_ready (fb_ready),
    .out_tok   (fb_tok),
    .bypass    (1'b0)
  );

  // --------------------------------------------------
  // Configuration and compute
  // --------------------------------------------------

  fabric_cfg u_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .busy      (busy),
    .cfg       (cfg)
  );

  fabric_pe u_pe (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .a_valid   (fa_valid),
    .a_ready   (fa_ready),
    .a_tok     (fa_tok),
    .b_valid   (fb_valid),
    .b_ready   (fb_ready),
    .b_tok     (fb_tok),
    .res_valid (pe_valid),
    .res_ready (pe_ready),
    .res_tok   (pe_tok),
    .err_tag   (err_tag)
  );

  // Output buffer, bypass from config
  fabric_fifo #(
    .DEPTH (`FABRIC_OUT_DEPTH)
  ) u_fifo_out (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (pe_valid),
    .in_ready  (pe_ready),
    .in_tok    (pe_tok),
    .out_valid (res_valid),
    .out_ready (res_ready),
    .out_tok   (res_tok),
    .bypass    (cfg.bypass_out)
  );

endmodule

`default_nettype wire

// File: source/fabric_pe.sv
`timescale 1ns/10ps
`default_nettype none

`include "fabric_params.svh"

// --------------------------------------------------
// Join of A and B, one operation, one output stage
// --------------------------------------------------
module fabric_pe (
  input  wire logic                      clk,
  input  wire logic                      rst_n,

  input  wire fabric_pkg::fabric_cfg_t   cfg,

  // Operand A
  input  wire logic                      a_valid,
  output logic                           a_ready,
  input  wire fabric_pkg::fabric_token_t a_tok,

  // Operand B, idle in constant mode
  input  wire logic                      b_valid,
  output logic                           b_ready,
  input  wire fabric_pkg::fabric_token_t b_tok,

  // Registered result
  output logic                           res_valid,
  input  wire logic                      res_ready,
  output fabric_pkg::fabric_token_t      res_tok,

  // Sticky tag mismatch
  output logic                           err_tag
);

  import fabric_pkg::*;

  logic                      can_accept;
  logic                      b_present;
  logic                      fire;
  logic [`FABRIC_DATA_W-1:0] opnd_a;
  logic [`FABRIC_DATA_W-1:0] opnd_b;
  logic [`FABRIC_DATA_W-1:0] result;
  logic                      tag_mismatch;

  // --------------------------------------------------
  // Handshake join
  // --------------------------------------------------

  // Output stage empty or draining this cycle
  assign can_accept = !res_valid || res_ready;

  // Constant stands in for B
  assign b_present = cfg.use_const || b_valid;

  assign fire = a_valid && b_present && can_accept;

  // Each side waits for its partner
  assign a_ready = b_present && can_accept;
  assign b_ready = !cfg.use_const && a_valid && can_accept;

  // --------------------------------------------------
  // Operation
  // --------------------------------------------------

  assign opnd_a = a_tok.data;
  assign opnd_b = cfg.use_const ? cfg.const_val : b_tok.data;

  // All arithmetic wraps at the data width
  always_comb begin
    case (cfg.op)
      OP_ADD:    result = opnd_a + opnd_b;
      OP_SUB:    result = opnd_a - opnd_b;
      OP_AND:    result = opnd_a & opnd_b;
      OP_OR:     result = opnd_a | opnd_b;
      OP_XOR:    result = opnd_a ^ opnd_b;
      // Shift amount from the low nibble
      OP_SHL:    result = opnd_a << opnd_b[3:0];
      OP_MAX:    result = (opnd_a > opnd_b) ? opnd_a : opnd_b;
      OP_PASS_A: result = opnd_a;
      default:   result = opnd_a;
    endcase
  end

  // Tags only compared when B is really joined
  assign tag_mismatch = fire && !cfg.use_const && (a_tok.tag != b_tok.tag);

  // --------------------------------------------------
  // Output stage
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else if (fire) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  // Result keeps the tag of A
  always_ff @(posedge clk) begin
    if (fire) begin
      res_tok.tag  <= a_tok.tag;
      res_tok.data <= result;
    end
  end

  // Set once, held until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_tag <= 1'b0;
    end else if (tag_mismatch) begin
      err_tag <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/fabric_cfg.sv
`timescale 1ns/10ps
`default_nettype none

`include "fabric_params.svh"

// --------------------------------------------------
// Tile configuration registers
// --------------------------------------------------
module fabric_cfg (
  input  wire logic                         clk,
  input  wire logic                         rst_n,

  // Write strobe, no handshake
  input  wire logic                         cfg_we,
  input  wire fabric_pkg::fabric_cfg_addr_e cfg_addr,
  input  wire logic [`FABRIC_DATA_W-1:0]    cfg_wdata,

  // Tokens somewhere in the tile
  input  wire logic                         busy,

  output fabric_pkg::fabric_cfg_t           cfg
);

  import fabric_pkg::*;

  // Register fields
  fabric_op_e                op_q;
  logic                      bypass_q;
  logic                      use_const_q;
  logic [`FABRIC_DATA_W-1:0] const_q;

  // Address decode and write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Pass A through, buffered, no constant
      op_q        <= OP_PASS_A;
      bypass_q    <= 1'b0;
      use_const_q <= 1'b0;
      const_q     <= '0;
    end else if (cfg_we) begin
      case (cfg_addr)
        CFG_OP: begin
          op_q <= fabric_op_e'(cfg_wdata[2:0]);
        end
        CFG_FLAGS: begin
          // Bit 0 output bypass, bit 1 constant operand
          bypass_q    <= cfg_wdata[0];
          use_const_q <= cfg_wdata[1];
        end
        CFG_CONST: begin
          const_q <= cfg_wdata;
        end
        default: begin
          // Unmapped address, write dropped
        end
      endcase
    end
  end

  // Packed view for the datapath
  assign cfg = '{
    op:         op_q,
    bypass_out: bypass_q,
    use_const:  use_const_q,
    const_val:  const_q
  };

  // Reconfiguring with tokens in flight would mix two setups
  a_no_write_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    cfg_we |-> !busy
  ) else $error("fabric_cfg: config write while tile busy");

endmodule

`default_nettype wire

// File: source/fabric_fifo.sv
`timescale 1ns/10ps
`default_nettype none

// --------------------------------------------------
// Stream buffer with optional zero-cycle bypass
// --------------------------------------------------
module fabric_fifo #(
  parameter int DEPTH = 2
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  // Upstream side
  input  wire logic                    in_valid,
  output logic                         in_ready,
  input  wire fabric_pkg::fabric_token_t in_tok,

  // Downstream side
  output logic                         out_valid,
  input  wire logic                    out_ready,
  output fabric_pkg::fabric_token_t    out_tok,

  // High selects the combinational path
  input  wire logic                    bypass
);

  import fabric_pkg::*;

  // Core-side stream
  logic          core_in_valid;
  logic          core_in_ready;
  fabric_token_t core_in_tok;
  logic          core_out_valid;
  logic          core_out_ready;
  fabric_token_t core_out_tok;

  // Path select
  always_comb begin
    if (bypass) begin
      // Straight wire from input to output
      out_valid      = in_valid;
      out_tok        = in_tok;
      in_ready       = out_ready;
      // Core sees no traffic
      core_in_valid  = 1'b0;
      core_in_tok    = '0;
      core_out_ready = 1'b0;
    end else begin
      // Everything goes through the buffer
      core_in_valid  = in_valid;
      core_in_tok    = in_tok;
      in_ready       = core_in_ready;
      out_valid      = core_out_valid;
      out_tok        = core_out_tok;
      core_out_ready = out_ready;
    end
  end

  fabric_fifo_core #(
    .DEPTH (DEPTH)
  ) u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (core_in_valid),
    .in_ready  (core_in_ready),
    .in_tok    (core_in_tok),
    .out_valid (core_out_valid),
    .out_ready (core_out_ready),
    .out_tok   (core_out_tok)
  );

  // Upstream must hold a stalled token unchanged
  a_in_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_tok))
  ) else $error("fabric_fifo: stalled input token changed");

endmodule

// --------------------------------------------------
// Circular buffer with head, tail and count
// --------------------------------------------------
module fabric_fifo_core #(
  parameter int DEPTH = 2
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  input  wire logic                    in_valid,
  output logic                         in_ready,
  input  wire fabric_pkg::fabric_token_t in_tok,

  output logic                         out_valid,
  input  wire logic                    out_ready,
  output fabric_pkg::fabric_token_t    out_tok
);

  import fabric_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  // Single slot buffers never accept while full
  localparam bit WRITE_THRU = (DEPTH > 1);

  // Slot storage, payload only
  fabric_token_t mem [DEPTH];

  logic [PTR_W-1:0] head;  // next write slot
  logic [PTR_W-1:0] tail;  // oldest entry
  logic [CNT_W-1:0] count;

  logic full;
  logic empty;
  logic do_write;
  logic do_read;

  // Advance with wrap at DEPTH-1, stays at 0 for one slot
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  assign out_valid = !empty;
  assign out_tok   = mem[tail];

  assign do_read  = out_valid && out_ready;
  // Full slot may be refilled when it is drained on the same edge
  assign in_ready = WRITE_THRU ? (!full || do_read) : !full;
  assign do_write = in_valid && in_ready;

  // Storage write
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[head] <= in_tok;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_write) begin
        head <= ptr_next(head);
      end
      if (do_read) begin
        tail <= ptr_next(tail);
      end
      // Simultaneous push and pop leave count alone
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(DEPTH)
  ) else $error("fabric_fifo_core: count above depth");

  // Pointers must agree that the popped slot holds a token
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    do_read |-> (full || (head != tail))
  ) else $error("fabric_fifo_core: pop from empty buffer");

endmodule

`default_nettype wire

// File: source/fabric_pkg.sv
`default_nettype none

`include "fabric_params.svh"

package fabric_pkg;

  // --------------------------------------------------
  // Stream token
  // --------------------------------------------------

  // Tag in the upper bits, data below it
  typedef struct packed {
    logic [`FABRIC_TAG_W-1:0]  tag;
    logic [`FABRIC_DATA_W-1:0] data;
  } fabric_token_t;

  // --------------------------------------------------
  // Operation and register map
  // --------------------------------------------------

  // Two-operand operations of the processing element
  typedef enum logic [2:0] {
    OP_ADD    = 3'd0,
    OP_SUB    = 3'd1,
    OP_AND    = 3'd2,
    OP_OR     = 3'd3,
    OP_XOR    = 3'd4,
    OP_SHL    = 3'd5,
    OP_MAX    = 3'd6,  // unsigned compare
    OP_PASS_A = 3'd7
  } fabric_op_e;

  // Register addresses, the top one is unmapped
  typedef enum logic [`FABRIC_CFG_AW-1:0] {
    CFG_OP    = 2'd0,
    CFG_FLAGS = 2'd1,
    CFG_CONST = 2'd2
  } fabric_cfg_addr_e;

  // Full tile configuration as seen by the datapath
  typedef struct packed {
    fabric_op_e                op;
    logic                      bypass_out;
    logic                      use_const;
    logic [`FABRIC_DATA_W-1:0] const_val;
  } fabric_cfg_t;

endpackage

`default_nettype wire

// File: source/fabric_params.svh
`ifndef FABRIC_PARAMS_SVH
`define FABRIC_PARAMS_SVH

// --------------------------------------------------
// Token widths
// --------------------------------------------------

// Payload carried by every token
`define FABRIC_DATA_W 16

// Tag travelling next to the payload
`define FABRIC_TAG_W 4

// --------------------------------------------------
// Buffering and configuration
// --------------------------------------------------

// Input buffers on the A and B streams
`define FABRIC_IN_DEPTH 2

// Result buffer ahead of the tile output
`define FABRIC_OUT_DEPTH 4

// Register address space of the config block
`define FABRIC_CFG_AW 2

`endif
